// File: eeprom_bus_pkg.sv
package eeprom_bus_pkg;

    // serial clock timing
    // one bit = 4 quarters, SCL high in quarters 1 and 2
    localparam int QUARTER_CYCLES = 2; // CLK cycles per quarter

    // bit engine command codes
    localparam int CMD_W = 2;

    localparam logic [CMD_W-1:0] CMD_START = 2'd0; // also used as repeated start
    localparam logic [CMD_W-1:0] CMD_STOP  = 2'd1;
    localparam logic [CMD_W-1:0] CMD_WRITE = 2'd2; // 8 bits out, ack in
    localparam logic [CMD_W-1:0] CMD_READ  = 2'd3; // 8 bits in, ack out

    // A start or a stop takes one bit period.
    // A byte takes nine, with the ack in the last one.
    localparam int BYTE_BITS = 9;

endpackage

// File: eeprom_ctrl.f
eeprom_bus_pkg.sv
eeprom_dev_pkg.sv
i2c_bit_engine.sv
eeprom_seq.sv
eeprom_ctrl.sv
eeprom_model.sv
eeprom_ctrl_sva.sv
tb_eeprom_ctrl.sv

// File: eeprom_ctrl.sv
module eeprom_ctrl
(
    input  logic                               CLK,
    input  logic                               RESET,
    input  logic                               req_valid,
    output logic                               req_ready,
    input  logic                               req_write,
    input  logic [eeprom_dev_pkg::ADDR_W-1:0]  req_addr,
    input  logic [eeprom_dev_pkg::DATA_W-1:0]  req_wdata,
    output logic                               resp_valid,
    input  logic                               resp_ready,
    output logic [eeprom_dev_pkg::DATA_W-1:0]  resp_rdata,
    output logic                               resp_nack,
    output logic                               scl,
    output logic                               sda_oe, // 1 pulls sda low
    input  logic                               sda_in
);

    logic                              cmd_valid;
    logic                              cmd_ready;
    logic [eeprom_bus_pkg::CMD_W-1:0]  cmd_code;
    logic [eeprom_dev_pkg::DATA_W-1:0] cmd_byte;
    logic                              cmd_ack_bit;
    logic                              done;
    logic [eeprom_dev_pkg::DATA_W-1:0] rx_byte;
    logic                              rx_nack;

    eeprom_seq i_seq
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_rdata  (resp_rdata),
        .resp_nack   (resp_nack),
        .cmd_valid   (cmd_valid),
        .cmd_code    (cmd_code),
        .cmd_byte    (cmd_byte),
        .cmd_ack_bit (cmd_ack_bit),
        .cmd_ready   (cmd_ready),
        .done        (done),
        .rx_byte     (rx_byte),
        .rx_nack     (rx_nack)
    );

    i2c_bit_engine i_bits
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .cmd_valid   (cmd_valid),
        .cmd_code    (cmd_code),
        .cmd_byte    (cmd_byte),
        .cmd_ack_bit (cmd_ack_bit),
        .cmd_ready   (cmd_ready),
        .done        (done),
        .rx_byte     (rx_byte),
        .rx_nack     (rx_nack),
        .scl         (scl),
        .sda_oe      (sda_oe),
        .sda_in      (sda_in)
    );

endmodule

// File: eeprom_ctrl_sva.sv
module eeprom_ctrl_sva
(
    input logic                              CLK,
    input logic                              RESET,
    input logic                              req_ready,
    input logic                              resp_valid,
    input logic                              resp_ready,
    input logic [eeprom_dev_pkg::DATA_W-1:0] resp_rdata,
    input logic                              resp_nack,
    input logic                              scl,
    input logic                              sda_oe
);

    resp_held: assert property (@(posedge CLK) disable iff (RESET)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata) && $stable(resp_nack))
        else $error("response changed while stalled");

    // a new request is taken only once the previous response has gone
    no_req_during_resp: assert property (@(posedge CLK) disable iff (RESET)
        $rose(req_ready) |-> $past(resp_valid && resp_ready))
        else $error("req_ready rose without a response transfer");

    // bus released between transactions
    bus_idle: assert property (@(posedge CLK) disable iff (RESET)
        (req_ready || resp_valid) |-> (scl && !sda_oe))
        else $error("bus not idle while the sequencer is idle");

endmodule

bind eeprom_ctrl eeprom_ctrl_sva i_sva
(
    .CLK        (CLK),
    .RESET      (RESET),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata),
    .resp_nack  (resp_nack),
    .scl        (scl),
    .sda_oe     (sda_oe)
);

// File: eeprom_dev_pkg.sv
package eeprom_dev_pkg;

    // 24C16 style part, 2K x 8
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // upper nibble of the control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // last bit of the control byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // the remaining control byte bits carry addr[10:8]
    localparam int PAGE_W = ADDR_W - DATA_W;

endpackage

// File: eeprom_model.sv
module eeprom_model
(
    input  logic CLK,
    input  logic present,
    input  logic scl,
    input  logic sda,
    output logic sda_oe
);

    logic [eeprom_dev_pkg::DATA_W-1:0] mem [1 << eeprom_dev_pkg::ADDR_W];
    logic [eeprom_dev_pkg::ADDR_W-1:0] addr   = '0;
    logic [7:0]                        shreg  = '0;
    logic [3:0]                        bitn   = '0; // scl rises seen in this byte
    logic [1:0]                        idx    = '0; // byte number since start
    logic                              active = 1'b0;
    logic                              tx     = 1'b0; // sending read data
    logic                              acked  = 1'b0;
    logic                              rw     = 1'b0;
    logic                              scl_q  = 1'b1;
    logic                              sda_q  = 1'b1;
    logic                              pull   = 1'b0;

    assign sda_oe = pull;

    initial
    begin
        for (int i = 0; i < (1 << eeprom_dev_pkg::ADDR_W); i++)
            mem[i] = {i[10:8], 5'd0} ^ i[7:0] ^ 8'h5a; // preset, differs per address
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (scl && scl_q && sda_q && !sda) // start or repeated start
        begin
            active <= present;
            tx     <= 1'b0;
            bitn   <= 4'd0;
            idx    <= 2'd0;
            pull   <= 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda) // stop
        begin
            active <= 1'b0;
            pull   <= 1'b0;
        end
        else if (active && scl && !scl_q)
        begin
            bitn <= bitn + 4'd1;
            if (bitn == 4'd8) // ack clock
            begin
                bitn <= 4'd0;
                idx  <= idx + 2'd1;
                if (tx || !acked)
                    active <= 1'b0;
                else if (idx == 2'd0 && rw == eeprom_dev_pkg::RW_READ)
                begin
                    tx    <= 1'b1;
                    shreg <= mem[addr];
                end
            end
            else if (tx)
                shreg <= {shreg[6:0], 1'b0};
            else
            begin
                shreg <= {shreg[6:0], sda};
                if (bitn == 4'd7)
                begin
                    case (idx)
                        2'd0:
                        begin
                            acked      <= (shreg[6:3] == eeprom_dev_pkg::DEV_CODE);
                            addr[10:8] <= shreg[2:0];
                            rw         <= sda;
                        end
                        2'd1:
                        begin
                            acked     <= 1'b1;
                            addr[7:0] <= {shreg[6:0], sda};
                        end
                        2'd2:
                        begin
                            acked     <= 1'b1;
                            mem[addr] = {shreg[6:0], sda};
                        end
                        default:
                            acked <= 1'b0; // no page writes
                    endcase
                end
            end
        end
        else if (active && !scl && scl_q) // sda only moves while scl low
            pull <= tx ? (bitn != 4'd8 && !shreg[7]) : (bitn == 4'd8 && acked);
    end

endmodule

// File: eeprom_seq.sv
module eeprom_seq
(
    input  logic                               CLK,
    input  logic                               RESET,
    input  logic                               req_valid,
    output logic                               req_ready,
    input  logic                               req_write,
    input  logic [eeprom_dev_pkg::ADDR_W-1:0]  req_addr,
    input  logic [eeprom_dev_pkg::DATA_W-1:0]  req_wdata,
    output logic                               resp_valid,
    input  logic                               resp_ready,
    output logic [eeprom_dev_pkg::DATA_W-1:0]  resp_rdata,
    output logic                               resp_nack,
    output logic                               cmd_valid,
    output logic [eeprom_bus_pkg::CMD_W-1:0]   cmd_code,
    output logic [eeprom_dev_pkg::DATA_W-1:0]  cmd_byte,
    output logic                               cmd_ack_bit,
    input  logic                               cmd_ready,
    input  logic                               done,
    input  logic [eeprom_dev_pkg::DATA_W-1:0]  rx_byte,
    input  logic                               rx_nack
);

    typedef enum logic [3:0]
    {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA,
        S_RSTART,
        S_CTRL_R,
        S_READ,
        S_STOP,
        S_RESP
    } state_t;

    state_t state;
    state_t next_state;
    logic   issued; // command taken, waiting for done
    logic   err;    // sticky nack

    logic                              write_q;
    logic [eeprom_dev_pkg::ADDR_W-1:0] addr_q;
    logic [eeprom_dev_pkg::DATA_W-1:0] wdata_q;
    logic [eeprom_dev_pkg::DATA_W-1:0] rdata_q;
    logic [eeprom_dev_pkg::PAGE_W-1:0] page;

    assign page       = addr_q[eeprom_dev_pkg::ADDR_W-1:eeprom_dev_pkg::DATA_W];
    assign req_ready  = (state == S_IDLE);
    assign resp_valid = (state == S_RESP);
    assign cmd_valid  = (state != S_IDLE) && (state != S_RESP) && !issued;
    assign cmd_ack_bit = (state == S_READ); // single byte read ends with nack

    always_comb
    begin
        case (state)
            S_START, S_RSTART:
                cmd_code = eeprom_bus_pkg::CMD_START;
            S_READ:
                cmd_code = eeprom_bus_pkg::CMD_READ;
            S_STOP:
                cmd_code = eeprom_bus_pkg::CMD_STOP;
            default:
                cmd_code = eeprom_bus_pkg::CMD_WRITE;
        endcase
        case (state)
            S_CTRL_W: cmd_byte = {eeprom_dev_pkg::DEV_CODE, page, eeprom_dev_pkg::RW_WRITE};
            S_CTRL_R: cmd_byte = {eeprom_dev_pkg::DEV_CODE, page, eeprom_dev_pkg::RW_READ};
            S_ADDR:   cmd_byte = addr_q[eeprom_dev_pkg::DATA_W-1:0];
            S_DATA:   cmd_byte = wdata_q;
            default:  cmd_byte = '0;
        endcase
    end

    // where to go once the current command is done
    always_comb
    begin
        case (state)
            S_START:  next_state = S_CTRL_W;
            S_CTRL_W: next_state = rx_nack ? S_STOP : S_ADDR;
            S_ADDR:   next_state = rx_nack ? S_STOP : (write_q ? S_DATA : S_RSTART);
            S_RSTART: next_state = S_CTRL_R;
            S_CTRL_R: next_state = rx_nack ? S_STOP : S_READ;
            S_STOP:   next_state = S_RESP;
            default:  next_state = S_STOP; // data, read
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= S_IDLE;
            issued <= 1'b0;
            err    <= 1'b0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                issued <= 1'b1;
            case (state)
                S_IDLE:
                    if (req_valid)
                    begin
                        err   <= 1'b0;
                        state <= S_START;
                    end
                S_RESP:
                    if (resp_ready)
                        state <= S_IDLE;
                default:
                    if (done)
                    begin
                        issued <= 1'b0;
                        if (rx_nack)
                            err <= 1'b1;
                        state <= next_state;
                    end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
        begin
            write_q <= req_write;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
        if (done && state == S_READ)
            rdata_q <= rx_byte;
        if (done && state == S_STOP) // response held until taken
        begin
            resp_rdata <= write_q ? '0 : rdata_q;
            resp_nack  <= err;
        end
    end

endmodule

// File: i2c_bit_engine.sv
module i2c_bit_engine
(
    input  logic                               CLK,
    input  logic                               RESET,
    input  logic                               cmd_valid,
    input  logic [eeprom_bus_pkg::CMD_W-1:0]   cmd_code,
    input  logic [7:0]                         cmd_byte,
    input  logic                               cmd_ack_bit,
    output logic                               cmd_ready,
    output logic                               done,
    output logic [7:0]                         rx_byte,
    output logic                               rx_nack,
    output logic                               scl,
    output logic                               sda_oe,
    input  logic                               sda_in
);

    localparam int QC_W = $clog2(eeprom_bus_pkg::QUARTER_CYCLES + 1);

    logic                             busy;
    logic [QC_W-1:0]                  qcnt;
    logic [1:0]                       phase;
    logic [3:0]                       bitcnt;
    logic [eeprom_bus_pkg::CMD_W-1:0] code_q;
    logic                             ack_q;
    logic [7:0]                       shreg;
    logic                             quarter_end;
    logic                             last_bit;

    // {scl, sda_oe} for a given phase of a given command
    function automatic logic [1:0] bus_level
    (
        input logic [eeprom_bus_pkg::CMD_W-1:0] code,
        input logic [1:0]                       ph,
        input logic                             is_last,
        input logic                             data_bit,
        input logic                             ack
    );
        logic clk_hi;
        logic oe;
        clk_hi = (ph == 2'd1) || (ph == 2'd2);
        case (code)
            eeprom_bus_pkg::CMD_START:
                oe = ph[1]; // sda falls while scl high
            eeprom_bus_pkg::CMD_STOP:
            begin
                oe = !ph[1]; // sda rises while scl high
                clk_hi = (ph != 2'd0); // scl left high for idle
            end
            eeprom_bus_pkg::CMD_WRITE:
                oe = is_last ? 1'b0 : !data_bit; // release for ack
            default:
                oe = is_last ? !ack : 1'b0;
        endcase
        return {clk_hi, oe};
    endfunction

    function automatic logic last_of(input logic [eeprom_bus_pkg::CMD_W-1:0] code,
                                     input logic [3:0] n);
        if (code == eeprom_bus_pkg::CMD_WRITE || code == eeprom_bus_pkg::CMD_READ)
            return n == 4'(eeprom_bus_pkg::BYTE_BITS - 1);
        return 1'b1;
    endfunction

    assign cmd_ready   = !busy;
    assign quarter_end = (qcnt == QC_W'(eeprom_bus_pkg::QUARTER_CYCLES - 1));
    assign last_bit    = last_of(code_q, bitcnt);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy   <= 1'b0;
            done   <= 1'b0;
            qcnt   <= '0;
            phase  <= 2'd0;
            bitcnt <= 4'd0;
            scl    <= 1'b1;
            sda_oe <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (!busy)
            begin
                if (cmd_valid)
                begin
                    busy   <= 1'b1;
                    qcnt   <= '0;
                    phase  <= 2'd0;
                    bitcnt <= 4'd0;
                    {scl, sda_oe} <= bus_level(cmd_code, 2'd0, last_of(cmd_code, 4'd0),
                                               cmd_byte[7], cmd_ack_bit);
                end
            end
            else if (quarter_end)
            begin
                qcnt <= '0;
                if (phase == 2'd3)
                begin
                    if (last_bit)
                    begin
                        busy <= 1'b0; // bus lines hold until next command
                        done <= 1'b1;
                    end
                    else
                    begin
                        bitcnt <= bitcnt + 4'd1;
                        phase  <= 2'd0;
                        {scl, sda_oe} <= bus_level(code_q, 2'd0, last_of(code_q, bitcnt + 4'd1),
                                                   shreg[6], ack_q);
                    end
                end
                else
                begin
                    phase <= phase + 2'd1;
                    {scl, sda_oe} <= bus_level(code_q, phase + 2'd1, last_bit, shreg[7], ack_q);
                end
            end
            else
                qcnt <= qcnt + QC_W'(1);
        end
    end

    // command payload and receive shift
    always_ff @(posedge CLK)
    begin
        if (!busy && cmd_valid)
        begin
            code_q  <= cmd_code;
            ack_q   <= cmd_ack_bit;
            shreg   <= cmd_byte;
            rx_nack <= 1'b0;
        end
        else if (busy && quarter_end)
        begin
            if (phase == 2'd1) // middle of scl high
            begin
                if (code_q == eeprom_bus_pkg::CMD_READ && !last_bit)
                    rx_byte <= {rx_byte[6:0], sda_in};
                if (code_q == eeprom_bus_pkg::CMD_WRITE && last_bit)
                    rx_nack <= sda_in;
            end
            if (phase == 2'd3)
                shreg <= {shreg[6:0], 1'b0}; // msb first
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_eeprom_ctrl -f eeprom_ctrl.f
./obj_dir/Vtb_eeprom_ctrl | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log
then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// File: tb_eeprom_ctrl.sv
module tb_eeprom_ctrl;

    localparam int N_ENTRIES    = 14;
    localparam int ENTRY_CYCLES = 400; // a random read is about 340 cycles
    localparam int DEPTH        = 1 << eeprom_dev_pkg::ADDR_W;

    logic                              CLK        = 1'b0;
    logic                              RESET      = 1'b1;
    logic                              req_valid  = 1'b0;
    logic                              req_ready;
    logic                              req_write  = 1'b0;
    logic [eeprom_dev_pkg::ADDR_W-1:0] req_addr   = '0;
    logic [eeprom_dev_pkg::DATA_W-1:0] req_wdata  = '0;
    logic                              resp_valid;
    logic                              resp_ready = 1'b0;
    logic [eeprom_dev_pkg::DATA_W-1:0] resp_rdata;
    logic                              resp_nack;
    logic                              scl;
    logic                              sda_oe;
    logic                              model_oe;
    logic                              present    = 1'b1;
    wire                               sda_in     = !(sda_oe || model_oe); // pull-up

    logic                              t_write   [N_ENTRIES];
    logic [eeprom_dev_pkg::ADDR_W-1:0] t_addr    [N_ENTRIES];
    logic [eeprom_dev_pkg::DATA_W-1:0] t_data    [N_ENTRIES];
    logic                              t_present [N_ENTRIES];
    int                                t_stall   [N_ENTRIES];
    logic [eeprom_dev_pkg::DATA_W-1:0] sb        [DEPTH]; // expected memory
    logic [31:0]                       rng    = 32'ha8bf3c7a;
    int                                n_rows = 0;
    int                                errors = 0;
    int                                cycles = 0;
    int                                limit  = 0;

    eeprom_ctrl i_dut (.*);

    eeprom_model i_model
    (
        .CLK    (CLK),
        .present(present),
        .scl    (scl),
        .sda    (sda_in),
        .sda_oe (model_oe)
    );

    always #4 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // preset contents of the part
    function automatic logic [7:0] fill_byte(input int a);
        return {a[10:8], 5'd0} ^ a[7:0] ^ 8'h5a;
    endfunction

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic add_entry(input logic wr, input logic [10:0] addr, input logic here);
        rng = xorshift(rng);
        t_write[n_rows]   = wr;
        t_addr[n_rows]    = addr;
        t_data[n_rows]    = rng[7:0];
        t_present[n_rows] = here;
        t_stall[n_rows]   = 32'(rng[10:8]);
        n_rows++;
    endtask

    task automatic run_entry(input int k);
        logic [7:0] exp_data;
        logic       exp_nack;
        logic [7:0] held_data;
        logic       held_nack;
        exp_nack  = !t_present[k];
        exp_data  = t_write[k] ? 8'h00 : sb[t_addr[k]];
        present   = t_present[k];
        req_write = t_write[k];
        req_addr  = t_addr[k];
        req_wdata = t_data[k];
        req_valid = 1'b1;
        while (req_ready !== 1'b1)
            next_cycle();
        next_cycle(); // taken on this edge
        req_valid = 1'b0;
        while (resp_valid !== 1'b1)
            next_cycle();
        held_data = resp_rdata;
        held_nack = resp_nack;
        if (resp_nack !== exp_nack)
        begin
            $display("mismatch at %0t: entry %0d resp_nack %b, expected %b",
                     $time, k, resp_nack, exp_nack);
            errors++;
        end
        if ((t_write[k] || !exp_nack) && resp_rdata !== exp_data)
        begin
            $display("mismatch at %0t: entry %0d resp_rdata %h, expected %h",
                     $time, k, resp_rdata, exp_data);
            errors++;
        end
        repeat (t_stall[k])
        begin
            next_cycle();
            if (resp_valid !== 1'b1 || req_ready !== 1'b0 ||
                resp_rdata !== held_data || resp_nack !== held_nack)
            begin
                $display("mismatch at %0t: entry %0d response not held during stall", $time, k);
                errors++;
            end
        end
        resp_ready = 1'b1;
        next_cycle();
        resp_ready = 1'b0;
        if (resp_valid !== 1'b0)
        begin
            $display("mismatch at %0t: entry %0d response still valid after transfer", $time, k);
            errors++;
        end
        if (t_write[k] && t_present[k])
            sb[t_addr[k]] = t_data[k];
    endtask

    initial
    begin
        for (int i = 0; i < DEPTH; i++)
            sb[i] = fill_byte(i);
        add_entry(1'b1, 11'h012, 1'b1);
        add_entry(1'b0, 11'h012, 1'b1);
        add_entry(1'b1, 11'h112, 1'b1); // same low byte, other pages
        add_entry(1'b1, 11'h712, 1'b1);
        add_entry(1'b0, 11'h012, 1'b1);
        add_entry(1'b0, 11'h112, 1'b1);
        add_entry(1'b0, 11'h712, 1'b1);
        add_entry(1'b0, 11'h6ff, 1'b1); // never written
        add_entry(1'b1, 11'h3a5, 1'b1);
        add_entry(1'b1, 11'h3a5, 1'b0); // part absent
        add_entry(1'b0, 11'h3a5, 1'b0);
        add_entry(1'b0, 11'h3a5, 1'b1);
        add_entry(1'b1, 11'h4c0, 1'b1);
        add_entry(1'b0, 11'h4c0, 1'b1);
        limit = 100;
        for (int k = 0; k < n_rows; k++)
            limit += ENTRY_CYCLES + t_stall[k];
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;
        if (scl !== 1'b1 || sda_oe !== 1'b0 || resp_valid !== 1'b0 || req_ready !== 1'b1)
        begin
            $display("mismatch at %0t: after reset scl %b sda_oe %b resp_valid %b req_ready %b",
                     $time, scl, sda_oe, resp_valid, req_ready);
            errors++;
        end
        for (int k = 0; k < n_rows; k++)
            run_entry(k);
        $display("entries %0d, errors %0d", n_rows, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
